// File: include/objectCache_params.svh
`ifndef OBJECT_CACHE_PARAMS_SVH
`define OBJECT_CACHE_PARAMS_SVH

//--------------------------------------------------------------------------
// data path widths
//--------------------------------------------------------------------------
// host io word
`define DATA_W 32
// object selector
`define SEL_W 24
// object length
`define LEN_W 32
// free space totals, wider than one length
`define MEM_W 40
// condition and read word selects
`define MUXSEL_W 3

// free objects cache, two halves of 128 entries
`define RAM_AW 8
`define RAM_DEPTH 256

//--------------------------------------------------------------------------
// host write strobes
//--------------------------------------------------------------------------
`define STB_W 4
`define STB_CONTROL 3
`define STB_LENGTH 6
`define STB_SELECTOR 7

// control word field positions
`define CTL_RDSEL_LO 0
`define CTL_CMD_LO 4
`define CTL_COND_LO 8
`define CTL_READY_BIT 11
`define CTL_MEMOP_LO 12

// read word select codes
`define RDSEL_FOUND 0
`define RDSEL_FREEMEM 4
`define RDSEL_CACHED 5

`endif

// File: source/objectCachePkg.sv
`default_nettype none

package objectCachePkg;

	// cache command field of the control word
	typedef enum logic [3:0] {
		cmdNone = 4'd0,
		cmdWrite = 4'd1,
		cmdClear = 4'd2,
		cmdFindFree = 4'd3,
		cmdCalc = 4'd4,
		cmdFindLength = 4'd5,
		cmdFindFreeLow = 4'd6,
		cmdFindEntry = 4'd7
	} cacheCmd_t;

	// owner of a read travelling down the ram pipeline
	typedef enum logic [2:0] {
		kindIdle = 3'd0,
		kindClear = 3'd1,
		kindFreePos = 3'd2,
		kindLength = 3'd3,
		kindEntry = 3'd4,
		kindCalc = 3'd5
	} scanKind_t;

	// free memory instruction
	typedef enum logic [1:0] {
		opHold = 2'd0,
		opZero = 2'd1,
		opAdd = 2'd2,
		opSub = 2'd3
	} memOp_t;

endpackage

`default_nettype wire

// File: source/hostRegisters.sv
`timescale 1ns/10ps
`default_nettype none
`include "objectCache_params.svh"

module hostRegisters import objectCachePkg::*; (
	input logic CLK,
	input logic RESETn,
	input logic [`STB_W-1:0] ioWriteStrobe,
	input logic [`DATA_W-1:0] ioWriteData,
	output logic cmdStb,
	output cacheCmd_t cmdCode,
	output logic [`LEN_W-1:0] lengthReg,
	output logic [`SEL_W-1:0] selReg,
	output logic memOpStb,
	output memOp_t memOp,
	output logic readySet,
	output logic [`MUXSEL_W-1:0] condSel,
	output logic [`MUXSEL_W-1:0] readSel
);

	logic ctlWr;
	logic [$bits(cacheCmd_t)-1:0] cmdField;
	logic [$bits(memOp_t)-1:0] opField;

	// strobe decode
	assign ctlWr = (ioWriteStrobe == `STB_CONTROL);
	// fields of the control word
	assign cmdField = ioWriteData[`CTL_CMD_LO +: $bits(cacheCmd_t)];
	assign opField = ioWriteData[`CTL_MEMOP_LO +: $bits(memOp_t)];

	//--------------------------------------------------------------------------
	// control word
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			cmdStb <= 1'b0;
			cmdCode <= cmdNone;
			memOpStb <= 1'b0;
			memOp <= opHold;
			readySet <= 1'b0;
			condSel <= '0;
			readSel <= '0;
		end else begin
			// command pulse only for a nonzero command field
			cmdStb <= ctlWr && (cmdField != '0);
			// instruction pulse, hold needs none
			memOpStb <= ctlWr && (opField != '0);
			// ready request, also drops the allocation lock
			readySet <= ctlWr && ioWriteData[`CTL_READY_BIT];
			if (ctlWr) begin
				cmdCode <= cacheCmd_t'(cmdField);
				memOp <= memOp_t'(opField);
				// mux selects stay as levels
				condSel <= ioWriteData[`CTL_COND_LO +: `MUXSEL_W];
				readSel <= ioWriteData[`CTL_RDSEL_LO +: `MUXSEL_W];
			end
		end
	end

	//--------------------------------------------------------------------------
	// length and selector
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		// requested object length
		if (ioWriteStrobe == `STB_LENGTH) begin
			lengthReg <= ioWriteData[`LEN_W-1:0];
		end
		// selector for cache writes, upper bits dropped
		if (ioWriteStrobe == `STB_SELECTOR) begin
			selReg <= ioWriteData[`SEL_W-1:0];
		end
	end

endmodule

`default_nettype wire

// File: source/freeListScan.sv
`timescale 1ns/10ps
`default_nettype none
`include "objectCache_params.svh"

module freeListScan import objectCachePkg::*; (
	input logic CLK,
	input logic RESETn,
	input logic cmdStb,
	input cacheCmd_t cmdCode,
	input logic [`LEN_W-1:0] lengthReg,
	input logic [`SEL_W-1:0] selReg,
	output logic busy,
	output logic freeFound,
	output logic lengthFound,
	output logic entryFound,
	output logic [`LEN_W-1:0] foundLength,
	output logic [`SEL_W-1:0] foundSelector,
	output logic [`MEM_W-1:0] cachedMem
);

	// entry is selector in the high bits, length in the low bits
	logic [`SEL_W+`LEN_W-1:0] cacheRam [0:`RAM_DEPTH-1];
	logic [`SEL_W+`LEN_W-1:0] ramQ;
	logic [`SEL_W+`LEN_W-1:0] dataQ;
	logic ramWr;
	logic [`SEL_W+`LEN_W-1:0] ramWrData;

	logic [`RAM_AW-1:0] scanAddr;
	logic issuing;
	scanKind_t scanKind;
	scanKind_t startKind;
	logic startUpper;
	logic scanStart;
	logic issue;
	logic lastAddr;

	// stage 0 is the ram address register, stage 2 holds dataQ
	scanKind_t pipeKind [0:2];
	logic [`RAM_AW-1:0] pipeAddr [0:2];
	logic [`SEL_W-1:0] hitSel;
	logic [`LEN_W-1:0] hitLen;
	logic hit;

	//--------------------------------------------------------------------------
	// command decode
	//--------------------------------------------------------------------------
	always_comb begin
		startKind = kindIdle;
		startUpper = 1'b0;
		case (cmdCode)
			cmdClear: startKind = kindClear;
			cmdFindFree: begin
				startKind = kindFreePos;
				startUpper = 1'b1;
			end
			cmdCalc: begin
				startKind = kindCalc;
				startUpper = 1'b1;
			end
			cmdFindLength: begin
				startKind = kindLength;
				startUpper = 1'b1;
			end
			cmdFindFreeLow: startKind = kindFreePos;
			cmdFindEntry: startKind = kindEntry;
			// none and write start no scan
			default: startKind = kindIdle;
		endcase
	end

	assign scanStart = cmdStb && (startKind != kindIdle);
	// last entry of either half
	assign lastAddr = &scanAddr[`RAM_AW-2:0];
	// a match stops issuing in the same cycle
	assign issue = issuing && !hit;
	// busy until the pipeline is empty
	assign busy = issuing || (pipeKind[0] != kindIdle) || (pipeKind[1] != kindIdle)
		|| (pipeKind[2] != kindIdle);

	//--------------------------------------------------------------------------
	// cache ram, registered address and registered output
	//--------------------------------------------------------------------------
	assign ramWr = (cmdStb && (cmdCode == cmdWrite)) || (issue && (scanKind == kindClear));
	assign ramWrData = (scanKind == kindClear && issuing) ? '0 : {selReg, lengthReg};

	initial begin
		for (int i = 0; i < `RAM_DEPTH; i++) begin
			cacheRam[i] = '0;
		end
	end

	always_ff @(posedge CLK) begin
		// writes go to the scan address
		if (ramWr) begin
			cacheRam[scanAddr] <= ramWrData;
		end
		ramQ <= cacheRam[pipeAddr[0]];
		// extra register to decide on
		dataQ <= ramQ;
		pipeAddr[0] <= scanAddr;
		pipeAddr[1] <= pipeAddr[0];
		pipeAddr[2] <= pipeAddr[1];
	end

	// match check on the oldest read
	assign hitSel = dataQ[`SEL_W+`LEN_W-1:`LEN_W];
	assign hitLen = dataQ[`LEN_W-1:0];

	always_comb begin
		case (pipeKind[2])
			// empty position
			kindFreePos: hit = (hitSel == '0);
			// object big enough
			kindLength: hit = (hitLen >= lengthReg);
			// used descriptor entry
			kindEntry: hit = (hitSel != '0);
			default: hit = 1'b0;
		endcase
	end

	//--------------------------------------------------------------------------
	// scan sequencer
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			scanAddr <= '0;
			issuing <= 1'b0;
			scanKind <= kindIdle;
			pipeKind[0] <= kindIdle;
			pipeKind[1] <= kindIdle;
			pipeKind[2] <= kindIdle;
		end else begin
			issuing <= scanStart || (issue && !lastAddr);
			if (scanStart) begin
				scanKind <= startKind;
			end
			// start of region, rewind on match, else step
			if (scanStart) begin
				scanAddr <= {startUpper, {(`RAM_AW-1){1'b0}}};
			end else if (hit) begin
				scanAddr <= pipeAddr[2];
			end else if (issue && !lastAddr) begin
				scanAddr <= scanAddr + 1'b1;
			end
			// younger reads are dropped after a match
			pipeKind[0] <= issue ? scanKind : kindIdle;
			pipeKind[1] <= hit ? kindIdle : pipeKind[0];
			pipeKind[2] <= hit ? kindIdle : pipeKind[1];
		end
	end

	//--------------------------------------------------------------------------
	// results
	//--------------------------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			freeFound <= 1'b0;
			lengthFound <= 1'b0;
			entryFound <= 1'b0;
			foundLength <= '0;
			foundSelector <= '0;
			cachedMem <= '0;
		end else begin
			// flags clear at start of their own scan
			if (scanStart && startKind == kindFreePos) begin
				freeFound <= 1'b0;
			end else if (hit && pipeKind[2] == kindFreePos) begin
				freeFound <= 1'b1;
			end
			if (scanStart && startKind == kindLength) begin
				lengthFound <= 1'b0;
			end else if (hit && pipeKind[2] == kindLength) begin
				lengthFound <= 1'b1;
			end
			if (scanStart && startKind == kindEntry) begin
				entryFound <= 1'b0;
			end else if (hit && pipeKind[2] == kindEntry) begin
				entryFound <= 1'b1;
			end
			// matching entry contents
			if (hit) begin
				foundLength <= hitLen;
				foundSelector <= hitSel;
			end
			// calc sums every upper half length
			if (scanStart && startKind == kindCalc) begin
				cachedMem <= '0;
			end else if (pipeKind[2] == kindCalc) begin
				cachedMem <= cachedMem + {{(`MEM_W-`LEN_W){1'b0}}, hitLen};
			end
		end
	end

endmodule

`default_nettype wire

// File: source/freeSpaceAccount.sv
`timescale 1ns/10ps
`default_nettype none
`include "objectCache_params.svh"

module freeSpaceAccount import objectCachePkg::*; (
	input logic CLK,
	input logic RESETn,
	input logic enable,
	input logic allocLock,
	input logic memOpStb,
	input memOp_t memOp,
	input logic [`LEN_W-1:0] lengthReg,
	input logic readySet,
	output logic [`MEM_W-1:0] freeMem,
	output logic ready,
	output logic allocResetReq
);

	logic lockFlag;
	logic allocLockQ;
	logic [`MEM_W-1:0] lengthExt;

	assign lengthExt = {{(`MEM_W-`LEN_W){1'b0}}, lengthReg};

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			freeMem <= '0;
			lockFlag <= 1'b1;
			allocLockQ <= 1'b0;
			allocResetReq <= 1'b0;
			ready <= 1'b0;
		end else begin
			// free memory instruction
			if (memOpStb) begin
				case (memOp)
					opZero: freeMem <= '0;
					opAdd: freeMem <= freeMem + lengthExt;
					// object header takes one more unit
					opSub: freeMem <= freeMem - lengthExt - 1'b1;
					default: freeMem <= freeMem;
				endcase
			end
			// lock follows allocLock, released by ready request
			lockFlag <= (lockFlag || allocLock) && !readySet;
			// falling edge of allocLock
			allocLockQ <= allocLock;
			// reset request only while still locked
			allocResetReq <= !allocLock && allocLockQ && lockFlag;
			// ready holds while enabled and unlocked
			ready <= (ready || readySet) && enable && !allocLock;
		end
	end

endmodule

`default_nettype wire

// File: source/statusSelect.sv
`timescale 1ns/10ps
`default_nettype none
`include "objectCache_params.svh"

module statusSelect (
	input logic [`MUXSEL_W-1:0] condSel,
	input logic [`MUXSEL_W-1:0] readSel,
	input logic busy,
	input logic freeFound,
	input logic lengthFound,
	input logic entryFound,
	input logic [`LEN_W-1:0] foundLength,
	input logic [`SEL_W-1:0] foundSelector,
	input logic [`MEM_W-1:0] cachedMem,
	input logic [`MEM_W-1:0] freeMem,
	output logic condFlag,
	output logic [`DATA_W-1:0] ioReadData0,
	output logic [`DATA_W-1:0] ioReadData1
);

	// condition flag for host branches
	always_comb begin
		case (condSel)
			3'd0: condFlag = busy;
			3'd1: condFlag = freeFound;
			3'd2: condFlag = lengthFound;
			3'd3: condFlag = entryFound;
			default: condFlag = 1'b0;
		endcase
	end

	// read words, totals split low word then top byte
	always_comb begin
		ioReadData0 = '0;
		ioReadData1 = '0;
		case (readSel)
			`RDSEL_FOUND: begin
				ioReadData0 = foundLength;
				ioReadData1 = {{(`DATA_W-`SEL_W){1'b0}}, foundSelector};
			end
			`RDSEL_FREEMEM: begin
				ioReadData0 = freeMem[`DATA_W-1:0];
				ioReadData1 = {{(2*`DATA_W-`MEM_W){1'b0}}, freeMem[`MEM_W-1:`DATA_W]};
			end
			`RDSEL_CACHED: begin
				ioReadData0 = cachedMem[`DATA_W-1:0];
				ioReadData1 = {{(2*`DATA_W-`MEM_W){1'b0}}, cachedMem[`MEM_W-1:`DATA_W]};
			end
			default: ioReadData0 = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: source/objectCacheTop.sv
`timescale 1ns/10ps
`default_nettype none
`include "objectCache_params.svh"

module objectCacheTop import objectCachePkg::*; (
	input logic CLK,
	input logic RESETn,
	input logic enable,
	input logic allocLock,
	input logic [`STB_W-1:0] ioWriteStrobe,
	input logic [`DATA_W-1:0] ioWriteData,
	output logic condFlag,
	output logic [`DATA_W-1:0] ioReadData0,
	output logic [`DATA_W-1:0] ioReadData1,
	output logic [`MEM_W-1:0] freeMem,
	output logic [`MEM_W-1:0] cachedMem,
	output logic ready,
	output logic allocResetReq
);

	// host register outputs
	logic cmdStb;
	cacheCmd_t cmdCode;
	logic [`LEN_W-1:0] lengthReg;
	logic [`SEL_W-1:0] selReg;
	logic memOpStb;
	memOp_t memOp;
	logic readySet;
	logic [`MUXSEL_W-1:0] condSel;
	logic [`MUXSEL_W-1:0] readSel;
	// scan status
	logic busy;
	logic freeFound;
	logic lengthFound;
	logic entryFound;
	logic [`LEN_W-1:0] foundLength;
	logic [`SEL_W-1:0] foundSelector;

	hostRegisters regs (.CLK(CLK), .RESETn(RESETn), .ioWriteStrobe(ioWriteStrobe),
		.ioWriteData(ioWriteData), .cmdStb(cmdStb), .cmdCode(cmdCode), .lengthReg(lengthReg),
		.selReg(selReg), .memOpStb(memOpStb), .memOp(memOp), .readySet(readySet),
		.condSel(condSel), .readSel(readSel));

	freeListScan scan (.CLK(CLK), .RESETn(RESETn), .cmdStb(cmdStb), .cmdCode(cmdCode),
		.lengthReg(lengthReg), .selReg(selReg), .busy(busy), .freeFound(freeFound),
		.lengthFound(lengthFound), .entryFound(entryFound), .foundLength(foundLength),
		.foundSelector(foundSelector), .cachedMem(cachedMem));

	freeSpaceAccount account (.CLK(CLK), .RESETn(RESETn), .enable(enable),
		.allocLock(allocLock), .memOpStb(memOpStb), .memOp(memOp), .lengthReg(lengthReg),
		.readySet(readySet), .freeMem(freeMem), .ready(ready), .allocResetReq(allocResetReq));

	statusSelect status (.condSel(condSel), .readSel(readSel), .busy(busy),
		.freeFound(freeFound), .lengthFound(lengthFound), .entryFound(entryFound),
		.foundLength(foundLength), .foundSelector(foundSelector), .cachedMem(cachedMem),
		.freeMem(freeMem), .condFlag(condFlag), .ioReadData0(ioReadData0),
		.ioReadData1(ioReadData1));

endmodule

`default_nettype wire

// File: test/clockGen.sv
`timescale 1ns/10ps
`default_nettype none

module clockGen #(
	parameter int halfPeriod = 50,
	parameter int resetCycles = 3
) (
	output logic CLK,
	output logic RESETn
);

	// free running clock
	initial begin
		CLK = 1'b0;
		forever #(halfPeriod) CLK = ~CLK;
	end

	// reset held over the first rising edges
	initial begin
		RESETn = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		RESETn <= 1'b1;
	end

endmodule

`default_nettype wire

// File: test/objectCacheTb.sv
`timescale 1ns/10ps
`default_nettype none
`include "objectCache_params.svh"

module objectCacheTb import objectCachePkg::*; ();

	localparam int clkPeriod = 100;
	localparam int numEntries = 6;
	localparam int numOps = 8;
	// cycles allowed for busy to show up after a command write
	localparam int riseLimit = 4;
	// one half of the cache plus the read pipeline
	localparam int scanLimit = `RAM_DEPTH / 2 + 8;
	localparam int scanCost = scanLimit + riseLimit + 12;
	// all tests at their slowest
	localparam int testCycles = 20 + numOps * 10 + (numEntries + 1) * 2 * scanCost
		+ 7 * scanCost + 40;

	logic CLK;
	logic RESETn;
	logic enable;
	logic allocLock;
	logic [`STB_W-1:0] ioWriteStrobe;
	logic [`DATA_W-1:0] ioWriteData;
	logic condFlag;
	logic [`DATA_W-1:0] ioReadData0;
	logic [`DATA_W-1:0] ioReadData1;
	logic [`MEM_W-1:0] freeMem;
	logic [`MEM_W-1:0] cachedMem;
	logic ready;
	logic allocResetReq;

	// entries written into the upper half
	logic [`LEN_W-1:0] lenTable [numEntries];
	logic [`SEL_W-1:0] selTable [numEntries];

	clockGen #(.halfPeriod(clkPeriod / 2), .resetCycles(3)) clocks (.CLK(CLK), .RESETn(RESETn));

	objectCacheTop uut (.CLK(CLK), .RESETn(RESETn), .enable(enable), .allocLock(allocLock),
		.ioWriteStrobe(ioWriteStrobe), .ioWriteData(ioWriteData), .condFlag(condFlag),
		.ioReadData0(ioReadData0), .ioReadData1(ioReadData1), .freeMem(freeMem),
		.cachedMem(cachedMem), .ready(ready), .allocResetReq(allocResetReq));

	//--------------------------------------------------------------------------
	// helpers
	//--------------------------------------------------------------------------
	task checkValue(input logic [63:0] actual, input logic [63:0] expected, input string what);
		if (actual !== expected) begin
			$display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, actual,
				expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// one host write with the strobe held for a single edge
	task hostWrite(input logic [`STB_W-1:0] strobe, input logic [`DATA_W-1:0] data);
		@(posedge CLK);
		ioWriteStrobe <= strobe;
		ioWriteData <= data;
		@(posedge CLK);
		ioWriteStrobe <= '0;
		ioWriteData <= '0;
	endtask

	// control word built from its field layout
	task writeControl(input cacheCmd_t cmd, input logic [2:0] cond, input logic [2:0] rdSel,
		input logic readyBit, input memOp_t op);
		logic [`DATA_W-1:0] word;
		word = '0;
		word[2:0] = rdSel;
		word[7:4] = cmd;
		word[10:8] = cond;
		word[11] = readyBit;
		word[13:12] = op;
		hostWrite(`STB_CONTROL, word);
	endtask

	// register pulse lands one edge later
	task waitUpdate();
		@(posedge CLK);
		@(negedge CLK);
	endtask

	// busy on condFlag must rise and then fall
	task waitScan(input string what);
		int cycles;
		cycles = 0;
		@(negedge CLK);
		while (condFlag !== 1'b1) begin
			cycles++;
			if (cycles > riseLimit) begin
				$display("Error at %0t ns: busy never went high for %s", $time, what);
				$display("Test failed");
				$fatal(1);
			end
			@(negedge CLK);
		end
		cycles = 0;
		while (condFlag !== 1'b0) begin
			cycles++;
			if (cycles > scanLimit) begin
				$display("Error at %0t ns: busy stayed high too long for %s", $time, what);
				$display("Test failed");
				$fatal(1);
			end
			@(negedge CLK);
		end
	endtask

	task runScan(input cacheCmd_t cmd, input string what);
		writeControl(cmd, 3'd0, 3'd0, 1'b0, opHold);
		waitScan(what);
	endtask

	// new mux selects without a command
	task selectStatus(input logic [2:0] cond, input logic [2:0] rdSel);
		writeControl(cmdNone, cond, rdSel, 1'b0, opHold);
		@(negedge CLK);
	endtask

	task writeEntry(input logic [`SEL_W-1:0] sel, input logic [`LEN_W-1:0] len);
		hostWrite(`STB_SELECTOR, sel);
		hostWrite(`STB_LENGTH, len);
		writeControl(cmdWrite, 3'd0, 3'd0, 1'b0, opHold);
	endtask

	//--------------------------------------------------------------------------
	// tests
	//--------------------------------------------------------------------------
	task resetDefaults();
		checkValue(ready, 0, "ready after reset");
		checkValue(allocResetReq, 0, "allocResetReq after reset");
		checkValue(condFlag, 0, "condFlag after reset");
		checkValue(freeMem, 0, "freeMem after reset");
		checkValue(cachedMem, 0, "cachedMem after reset");
	endtask

	task freeSpaceTotals();
		memOp_t ops [numOps];
		logic [`MEM_W-1:0] model;
		logic [`LEN_W-1:0] len;
		ops = '{opZero, opAdd, opAdd, opSub, opAdd, opAdd, opSub, opZero};
		model = '0;
		for (int i = 0; i < numOps; i++) begin
			len = $urandom;
			hostWrite(`STB_LENGTH, len);
			writeControl(cmdNone, 3'd0, 3'd4, 1'b0, ops[i]);
			// subtract also takes one unit for the header
			case (ops[i])
				opZero: model = '0;
				opAdd: model = model + len;
				opSub: model = model - len - 1;
				default: model = model;
			endcase
			waitUpdate();
			checkValue(freeMem, model, "freeMem total");
			checkValue(ioReadData0, model[31:0], "freeMem low word");
			checkValue(ioReadData1, {24'd0, model[39:32]}, "freeMem high byte");
		end
	endtask

	task cacheWriteCalc();
		logic [`MEM_W-1:0] sum;
		sum = '0;
		for (int i = 0; i < numEntries; i++) begin
			runScan(cmdFindFree, "findFree");
			selectStatus(3'd1, 3'd0);
			checkValue(condFlag, 1, "freeFound");
			// lengths in disjoint bands make the last one the largest
			lenTable[i] = ((i + 1) << 20) + ($urandom & 32'hFFFFF);
			selTable[i] = $urandom | 1;
			sum = sum + lenTable[i];
			writeEntry(selTable[i], lenTable[i]);
		end
		runScan(cmdCalc, "calc");
		selectStatus(3'd0, 3'd5);
		checkValue(cachedMem, sum, "cachedMem sum");
		checkValue(ioReadData0, sum[31:0], "cachedMem low word");
		checkValue(ioReadData1, {24'd0, sum[39:32]}, "cachedMem high byte");
	endtask

	task lengthSearch();
		int last;
		last = numEntries - 1;
		// only the largest entry meets this
		hostWrite(`STB_LENGTH, lenTable[last]);
		runScan(cmdFindLength, "findLength");
		selectStatus(3'd2, 3'd0);
		checkValue(condFlag, 1, "lengthFound");
		checkValue(ioReadData0, lenTable[last], "found length");
		checkValue(ioReadData1, {8'd0, selTable[last]}, "found selector");
		// nothing is this big
		hostWrite(`STB_LENGTH, lenTable[last] + 1);
		runScan(cmdFindLength, "findLength too large");
		selectStatus(3'd2, 3'd0);
		checkValue(condFlag, 0, "lengthFound for oversized request");
	endtask

	task clearEntrySearch();
		logic [`LEN_W-1:0] len;
		logic [`SEL_W-1:0] sel;
		// used entry in the lower half that clear has to remove
		runScan(cmdFindFreeLow, "findFreeLow before clear");
		len = $urandom;
		sel = $urandom | 1;
		writeEntry(sel, len);
		runScan(cmdClear, "clear");
		runScan(cmdFindEntry, "findEntry on cleared half");
		selectStatus(3'd3, 3'd0);
		checkValue(condFlag, 0, "entryFound after clear");
		runScan(cmdFindFreeLow, "findFreeLow");
		selectStatus(3'd1, 3'd0);
		checkValue(condFlag, 1, "freeFound in lower half");
		len = $urandom;
		sel = $urandom | 1;
		writeEntry(sel, len);
		runScan(cmdFindEntry, "findEntry");
		selectStatus(3'd3, 3'd0);
		checkValue(condFlag, 1, "entryFound");
		checkValue(ioReadData0, len, "entry length");
		checkValue(ioReadData1, {8'd0, sel}, "entry selector");
	endtask

	task lockReady();
		int pulses;
		@(posedge CLK);
		allocLock <= 1'b1;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		checkValue(allocResetReq, 0, "allocResetReq while locked");
		@(posedge CLK);
		allocLock <= 1'b0;
		// count the pulse on the falling edge of allocLock
		pulses = 0;
		repeat (5) begin
			@(negedge CLK);
			if (allocResetReq === 1'b1) begin
				pulses++;
			end
		end
		checkValue(pulses, 1, "allocResetReq pulse width");
		writeControl(cmdNone, 3'd0, 3'd0, 1'b1, opHold);
		waitUpdate();
		checkValue(ready, 1, "ready after request");
		@(posedge CLK);
		allocLock <= 1'b1;
		waitUpdate();
		checkValue(ready, 0, "ready under allocLock");
	endtask

	//--------------------------------------------------------------------------
	// main sequence and watchdog
	//--------------------------------------------------------------------------
	initial begin
		void'($urandom(58));
		enable = 1'b1;
		allocLock = 1'b0;
		ioWriteStrobe = '0;
		ioWriteData = '0;
		wait (RESETn === 1'b1);
		@(negedge CLK);
		resetDefaults();
		freeSpaceTotals();
		cacheWriteCalc();
		lengthSearch();
		clearEntrySearch();
		lockReady();
		$display("Test completed successfully");
		$finish;
	end

	initial begin
		#(2 * testCycles * clkPeriod);
		$display("Timeout: tests still running after %0d cycles", 2 * testCycles);
		$display("Test failed");
		$fatal(1);
	end

endmodule

`default_nettype wire

// File: objectCacheTop.f
+incdir+include
source/objectCachePkg.sv
source/hostRegisters.sv
source/freeListScan.sv
source/freeSpaceAccount.sv
source/statusSelect.sv
source/objectCacheTop.sv
test/clockGen.sv
test/objectCacheTb.sv

// File: Bender.yml
package:
  name: object_cache

export_include_dirs:
  - include

sources:
  - files:
      - source/objectCachePkg.sv
      - source/hostRegisters.sv
      - source/freeListScan.sv
      - source/freeSpaceAccount.sv
      - source/statusSelect.sv
      - source/objectCacheTop.sv
  - target: test
    files:
      - test/clockGen.sv
      - test/objectCacheTb.sv
